// File: alu.sv
// Combinational RV32I integer ALU
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  logic [riscvPkg::xlen-1:0] op1,
    input  logic [riscvPkg::xlen-1:0] op2,
    input  riscvPkg::aluOpT           aluOp,
    output logic [riscvPkg::xlen-1:0] aluResult
);
    import riscvPkg::*;

    // Shift amount, low five bits only
    logic [4:0] shamt;
    // Signed and unsigned compare
    logic       lessSigned;
    logic       lessUnsigned;

    assign shamt = op2[4:0];
    assign lessSigned = $signed(op1) < $signed(op2);
    assign lessUnsigned = op1 < op2;

    always_comb begin
        case (aluOp)
            ADD: begin
                aluResult = op1 + op2;
            end
            SUB: begin
                aluResult = op1 - op2;
            end
            AND: begin
                aluResult = op1 & op2;
            end
            OR: begin
                aluResult = op1 | op2;
            end
            XOR: begin
                aluResult = op1 ^ op2;
            end
            SLL: begin
                aluResult = op1 << shamt;
            end
            SRL: begin
                aluResult = op1 >> shamt;
            end
            // Arithmetic shift keeps the sign bit
            SRA: begin
                aluResult = $unsigned($signed(op1) >>> shamt);
            end
            // Set-less-than gives 0 or 1
            SLT: begin
                aluResult = {{(xlen-1){1'b0}}, lessSigned};
            end
            SLTU: begin
                aluResult = {{(xlen-1){1'b0}}, lessUnsigned};
            end
            COPYB: begin
                aluResult = op2;
            end
            default: begin
                aluResult = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: exCore.sv
// Execute slice top with register file, ID/EX, forwarding, ALU and result pipe
`timescale 1ns/1ps
`default_nettype none

module exCore (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              issueValid,
    input  logic [riscvPkg::regAddrWidth-1:0] issueRs1,
    input  logic [riscvPkg::regAddrWidth-1:0] issueRs2,
    input  logic [riscvPkg::regAddrWidth-1:0] issueRd,
    input  logic                              issueRegWrite,
    input  riscvPkg::aluOpT                   issueAluOp,
    input  riscvPkg::srcAT                    issueSrcA,
    input  riscvPkg::srcBT                    issueSrcB,
    input  logic [riscvPkg::xlen-1:0]         issuePc,
    input  logic [riscvPkg::xlen-1:0]         issueImm,
    output logic                              wbValid,
    output logic [riscvPkg::regAddrWidth-1:0] wbRd,
    output logic [riscvPkg::xlen-1:0]         wbData
);
    import riscvPkg::*;

    // Issue stage read data
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    // ID/EX outputs
    logic exValid;
    logic [regAddrWidth-1:0] exRs1;
    logic [regAddrWidth-1:0] exRs2;
    logic [regAddrWidth-1:0] exRd;
    logic exRegWrite;
    aluOpT exAluOp;
    srcAT exSrcA;
    srcBT exSrcB;
    logic [xlen-1:0] exPc;
    logic [xlen-1:0] exImm;
    logic [xlen-1:0] exRs1Data;
    logic [xlen-1:0] exRs2Data;
    // Forward selects
    fwdSelT fwdA;
    fwdSelT fwdB;
    // Result path
    logic [xlen-1:0] aluResult;
    logic [regAddrWidth-1:0] memRd;
    logic memWrite;
    logic [xlen-1:0] memResult;
    logic wbWrite;

    // Written from the WB stage
    regFile regs (
        .CLK     (CLK),
        .rst     (rst),
        .rdAddrA (issueRs1),
        .rdAddrB (issueRs2),
        .wrAddr  (wbRd),
        .wrEn    (wbWrite),
        .wrData  (wbData),
        .rdDataA (rs1Data),
        .rdDataB (rs2Data)
    );

    idExReg idEx (
        .CLK           (CLK),
        .rst           (rst),
        .issueValid    (issueValid),
        .issueRs1      (issueRs1),
        .issueRs2      (issueRs2),
        .issueRd       (issueRd),
        .issueRegWrite (issueRegWrite),
        .issueAluOp    (issueAluOp),
        .issueSrcA     (issueSrcA),
        .issueSrcB     (issueSrcB),
        .issuePc       (issuePc),
        .issueImm      (issueImm),
        .rs1Data       (rs1Data),
        .rs2Data       (rs2Data),
        .exValid       (exValid),
        .exRs1         (exRs1),
        .exRs2         (exRs2),
        .exRd          (exRd),
        .exRegWrite    (exRegWrite),
        .exAluOp       (exAluOp),
        .exSrcA        (exSrcA),
        .exSrcB        (exSrcB),
        .exPc          (exPc),
        .exImm         (exImm),
        .exRs1Data     (exRs1Data),
        .exRs2Data     (exRs2Data)
    );

    forwardUnit fwd (
        .exRs1    (exRs1),
        .exRs2    (exRs2),
        .memRd    (memRd),
        .wbRd     (wbRd),
        .memWrite (memWrite),
        .wbWrite  (wbWrite),
        .fwdA     (fwdA),
        .fwdB     (fwdB)
    );

    // EX/MEM result is the one-back forward, WB data the two-back
    exe exUnit (
        .fwdA       (fwdA),
        .fwdB       (fwdB),
        .srcA       (exSrcA),
        .srcB       (exSrcB),
        .aluOp      (exAluOp),
        .fwdAluData (memResult),
        .fwdWbData  (wbData),
        .pc         (exPc),
        .imm        (exImm),
        .rs1Data    (exRs1Data),
        .rs2Data    (exRs2Data),
        .aluResult  (aluResult)
    );

    resultPipe results (
        .CLK        (CLK),
        .rst        (rst),
        .exValid    (exValid),
        .exRegWrite (exRegWrite),
        .exRd       (exRd),
        .aluResult  (aluResult),
        .memRd      (memRd),
        .memWrite   (memWrite),
        .memResult  (memResult),
        .wbValid    (wbValid),
        .wbWrite    (wbWrite),
        .wbRd       (wbRd),
        .wbData     (wbData)
    );

endmodule

`default_nettype wire

// File: exCore_assertions.sv
// Concurrent pipeline checks for exCore and their bind into it
`timescale 1ns/1ps
`default_nettype none

module exCoreAssertions (
    input logic                              CLK,
    input logic                              rst,
    input logic                              issueValid,
    input logic                              wbValid,
    input riscvPkg::fwdSelT                  fwdA,
    input logic [riscvPkg::regAddrWidth-1:0] exRs1
);
    import riscvPkg::*;

    // Fixed latency, one writeback per issue
    wbFollowsIssue: assert property (
        @(posedge CLK) disable iff (rst) wbValid == $past(issueValid, 3)
    ) else $error("wbValid does not match issueValid three cycles earlier");

    // x0 is never a forwarding source
    noForwardFromZero: assert property (
        @(posedge CLK) disable iff (rst) (fwdA != NOFORWARD) |-> (exRs1 != zeroReg)
    ) else $error("operand A forwarded for x0");

    // Cleared once reset has been seen for an edge
    wbLowInReset: assert property (
        @(posedge CLK) (rst && $past(rst)) |-> !wbValid
    ) else $error("wbValid high during reset");

endmodule

bind exCore exCoreAssertions assertChecks (
    .CLK        (CLK),
    .rst        (rst),
    .issueValid (issueValid),
    .wbValid    (wbValid),
    .fwdA       (fwdA),
    .exRs1      (exRs1)
);

`default_nettype wire

// File: exe.sv
// Execution unit with forwarding muxes, PC/IMM source muxes and the ALU
`timescale 1ns/1ps
`default_nettype none

module exe (
    input  riscvPkg::fwdSelT          fwdA,
    input  riscvPkg::fwdSelT          fwdB,
    input  riscvPkg::srcAT            srcA,
    input  riscvPkg::srcBT            srcB,
    input  riscvPkg::aluOpT           aluOp,
    input  logic [riscvPkg::xlen-1:0] fwdAluData,
    input  logic [riscvPkg::xlen-1:0] fwdWbData,
    input  logic [riscvPkg::xlen-1:0] pc,
    input  logic [riscvPkg::xlen-1:0] imm,
    input  logic [riscvPkg::xlen-1:0] rs1Data,
    input  logic [riscvPkg::xlen-1:0] rs2Data,
    output logic [riscvPkg::xlen-1:0] aluResult
);
    import riscvPkg::*;

    // Forwarded register operands
    logic [xlen-1:0] muxA;
    logic [xlen-1:0] muxB;
    // Final ALU operands
    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;

    alu aluUnit (
        .op1       (opA),
        .op2       (opB),
        .aluOp     (aluOp),
        .aluResult (aluResult)
    );

    always_comb begin
        // First level, forwarding into A
        case (fwdA)
            FORWARD_alu: muxA = fwdAluData;
            FORWARD_wb:  muxA = fwdWbData;
            default:     muxA = rs1Data;
        endcase

        // First level, forwarding into B
        case (fwdB)
            FORWARD_alu: muxB = fwdAluData;
            FORWARD_wb:  muxB = fwdWbData;
            default:     muxB = rs2Data;
        endcase

        // Second level, PC replaces A for AUIPC style ops
        case (srcA)
            PC:      opA = pc;
            default: opA = muxA;
        endcase

        // Immediate replaces B
        case (srcB)
            IMM:     opB = imm;
            default: opB = muxB;
        endcase
    end

endmodule

`default_nettype wire

// File: forwardUnit.sv
// Forwarding unit selecting EX/MEM or MEM/WB data for each ALU operand
`timescale 1ns/1ps
`default_nettype none

module forwardUnit (
    input  logic [riscvPkg::regAddrWidth-1:0] exRs1,
    input  logic [riscvPkg::regAddrWidth-1:0] exRs2,
    input  logic [riscvPkg::regAddrWidth-1:0] memRd,
    input  logic [riscvPkg::regAddrWidth-1:0] wbRd,
    input  logic                              memWrite,
    input  logic                              wbWrite,
    output riscvPkg::fwdSelT                  fwdA,
    output riscvPkg::fwdSelT                  fwdB
);
    import riscvPkg::*;

    // Select for one source register
    function automatic fwdSelT pickFwd(input logic [regAddrWidth-1:0] rs);
        fwdSelT sel;
        sel = NOFORWARD;
        // Youngest producer checked first so EX/MEM wins
        if (memWrite && memRd != zeroReg && memRd == rs) begin
            sel = FORWARD_alu;
        end else if (wbWrite && wbRd != zeroReg && wbRd == rs) begin
            sel = FORWARD_wb;
        end
        return sel;
    endfunction

    // Write flags already carry the stage valid bits
    always_comb begin
        fwdA = pickFwd(exRs1);
        fwdB = pickFwd(exRs2);
    end

endmodule

`default_nettype wire

// File: idExReg.sv
// ID/EX pipeline register for the issued instruction
`timescale 1ns/1ps
`default_nettype none

module idExReg (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              issueValid,
    input  logic [riscvPkg::regAddrWidth-1:0] issueRs1,
    input  logic [riscvPkg::regAddrWidth-1:0] issueRs2,
    input  logic [riscvPkg::regAddrWidth-1:0] issueRd,
    input  logic                              issueRegWrite,
    input  riscvPkg::aluOpT                   issueAluOp,
    input  riscvPkg::srcAT                    issueSrcA,
    input  riscvPkg::srcBT                    issueSrcB,
    input  logic [riscvPkg::xlen-1:0]         issuePc,
    input  logic [riscvPkg::xlen-1:0]         issueImm,
    input  logic [riscvPkg::xlen-1:0]         rs1Data,
    input  logic [riscvPkg::xlen-1:0]         rs2Data,
    output logic                              exValid,
    output logic [riscvPkg::regAddrWidth-1:0] exRs1,
    output logic [riscvPkg::regAddrWidth-1:0] exRs2,
    output logic [riscvPkg::regAddrWidth-1:0] exRd,
    output logic                              exRegWrite,
    output riscvPkg::aluOpT                   exAluOp,
    output riscvPkg::srcAT                    exSrcA,
    output riscvPkg::srcBT                    exSrcB,
    output logic [riscvPkg::xlen-1:0]         exPc,
    output logic [riscvPkg::xlen-1:0]         exImm,
    output logic [riscvPkg::xlen-1:0]         exRs1Data,
    output logic [riscvPkg::xlen-1:0]         exRs2Data
);
    import riscvPkg::*;

    // Control half
    always_ff @(posedge CLK) begin
        if (rst) begin
            exValid <= 1'b0;
            exRegWrite <= 1'b0;
            exAluOp <= ADD;
            exSrcA <= RS1;
            exSrcB <= RS2;
        end else begin
            exValid <= issueValid;
            // Bubble never writes
            exRegWrite <= issueValid && issueRegWrite;
            if (issueValid) begin
                exAluOp <= issueAluOp;
                exSrcA <= issueSrcA;
                exSrcB <= issueSrcB;
            end
        end
    end

    // Payload half, loaded on issue only
    always_ff @(posedge CLK) begin
        if (issueValid) begin
            exRs1 <= issueRs1;
            exRs2 <= issueRs2;
            exRd <= issueRd;
            exPc <= issuePc;
            exImm <= issueImm;
            exRs1Data <= rs1Data;
            exRs2Data <= rs2Data;
        end
    end

endmodule

`default_nettype wire

// File: project.f
riscvPkg.sv
alu.sv
exe.sv
forwardUnit.sv
regFile.sv
idExReg.sv
resultPipe.sv
exCore.sv
exCore_assertions.sv
tbExCore.sv

// File: regFile.sv
// 32x32 register file with zero x0 and write-through read bypass
`timescale 1ns/1ps
`default_nettype none

module regFile (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic [riscvPkg::regAddrWidth-1:0] rdAddrA,
    input  logic [riscvPkg::regAddrWidth-1:0] rdAddrB,
    input  logic [riscvPkg::regAddrWidth-1:0] wrAddr,
    input  logic                              wrEn,
    input  logic [riscvPkg::xlen-1:0]         wrData,
    output logic [riscvPkg::xlen-1:0]         rdDataA,
    output logic [riscvPkg::xlen-1:0]         rdDataB
);
    import riscvPkg::*;

    // Storage for x1..x31 only
    logic [xlen-1:0] regs [1:regCount-1];

    // One read port, bypassing a same-cycle write
    function automatic logic [xlen-1:0] readPort(input logic [regAddrWidth-1:0] addr);
        logic [xlen-1:0] value;
        if (addr == zeroReg) begin
            value = '0;
        end else if (wrEn && addr == wrAddr) begin
            value = wrData;
        end else begin
            value = regs[addr];
        end
        return value;
    endfunction

    always_ff @(posedge CLK) begin
        if (rst) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && wrAddr != zeroReg) begin
            regs[wrAddr] <= wrData;
        end
    end

    // Reads follow the storage and the write port as well as the addresses
    always_comb begin
        rdDataA = readPort(rdAddrA);
        rdDataB = readPort(rdAddrB);
    end

endmodule

`default_nettype wire

// File: resultPipe.sv
// EX/MEM and MEM/WB result registers feeding forwarding and writeback
`timescale 1ns/1ps
`default_nettype none

module resultPipe (
    input  logic                              CLK,
    input  logic                              rst,
    input  logic                              exValid,
    input  logic                              exRegWrite,
    input  logic [riscvPkg::regAddrWidth-1:0] exRd,
    input  logic [riscvPkg::xlen-1:0]         aluResult,
    output logic [riscvPkg::regAddrWidth-1:0] memRd,
    output logic                              memWrite,
    output logic [riscvPkg::xlen-1:0]         memResult,
    output logic                              wbValid,
    output logic                              wbWrite,
    output logic [riscvPkg::regAddrWidth-1:0] wbRd,
    output logic [riscvPkg::xlen-1:0]         wbData
);
    import riscvPkg::*;

    // Instruction present in MEM, writing or not
    logic memValid;

    // Stage control and destinations
    always_ff @(posedge CLK) begin
        if (rst) begin
            memValid <= 1'b0;
            memWrite <= 1'b0;
            memRd <= zeroReg;
            wbValid <= 1'b0;
            wbWrite <= 1'b0;
            wbRd <= zeroReg;
        end else begin
            memValid <= exValid;
            memWrite <= exRegWrite;
            memRd <= exRd;
            // MEM is a plain pass-through stage
            wbValid <= memValid;
            wbWrite <= memWrite;
            wbRd <= memRd;
        end
    end

    // Results
    always_ff @(posedge CLK) begin
        memResult <= aluResult;
        wbData <= memResult;
    end

endmodule

`default_nettype wire

// File: riscvPkg.sv
// Shared widths, register count and control enums for the execute slice
`default_nettype none

package riscvPkg;

    // Datapath width fixed by RV32I
    localparam int xlen = 32;

    // Register index width and number of architectural registers
    localparam int regAddrWidth = 5;
    localparam int regCount = 32;

    // Index of the hard-wired zero register
    localparam logic [regAddrWidth-1:0] zeroReg = '0;

    // ALU operation select
    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        XOR,
        SLL,
        SRL,
        SRA,
        SLT,
        SLTU,
        // Operand two straight through, LUI
        COPYB
    } aluOpT;

    // Source of each operand before the PC/IMM mux
    typedef enum logic [1:0] {
        NOFORWARD,
        FORWARD_alu,
        FORWARD_wb
    } fwdSelT;

    // Operand A source
    typedef enum logic {
        RS1,
        PC
    } srcAT;

    // Operand B source
    typedef enum logic {
        RS2,
        IMM
    } srcBT;

endpackage

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the exCore testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module tbExCore \
    -f project.f \
    -o simv

status=0
./obj_dir/simv > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "^Done: no errors$" sim.log; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed (exit status $status)"
exit 1

// File: tbExCore.sv
// Testbench for exCore with LFSR stimulus, in-order ISA model, check task and timeouts
`timescale 1ns/1ps
`default_nettype none

module tbExCore;
    import riscvPkg::*;

    logic CLK;
    logic rst;
    logic issueValid;
    logic [regAddrWidth-1:0] issueRs1;
    logic [regAddrWidth-1:0] issueRs2;
    logic [regAddrWidth-1:0] issueRd;
    logic issueRegWrite;
    aluOpT issueAluOp;
    srcAT issueSrcA;
    srcBT issueSrcB;
    logic [xlen-1:0] issuePc;
    logic [xlen-1:0] issueImm;
    logic wbValid;
    logic [regAddrWidth-1:0] wbRd;
    logic [xlen-1:0] wbData;

    // Architectural state of the model
    logic [xlen-1:0] modelRegs [0:regCount-1];
    // Expected writebacks in program order
    logic [regAddrWidth-1:0] expRd [$];
    logic [xlen-1:0] expData [$];
    int expCycle [$];
    logic [31:0] lfsrState;
    int cycleNum;
    int idleCycles;
    int errorCount;

    exCore DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;
    end

    // Fibonacci LFSR, taps 32 22 2 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    // One LFSR step per bit taken
    task automatic drawBits(input int count, output logic [31:0] value);
        value = '0;
        for (int i = 0; i < count; i++) begin
            lfsrState = lfsrNext(lfsrState);
            value = {value[30:0], lfsrState[0]};
        end
    endtask

    // RV32I semantics written from the ISA
    function automatic logic [xlen-1:0] modelAlu(input aluOpT op, input logic [xlen-1:0] a,
                                                 input logic [xlen-1:0] b);
        logic [4:0] sh;
        logic [xlen-1:0] r;
        sh = b[4:0];
        case (op)
            ADD: r = a + b;
            SUB: r = a + ~b + 32'd1;
            AND: r = a & b;
            OR: r = a | b;
            XOR: r = a ^ b;
            SLL: r = a << sh;
            SRL: r = a >> sh;
            // Fill vacated top bits with the sign
            SRA: r = (a >> sh) | (a[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
            // Differing signs decide the signed compare alone
            SLT: r = (a[31] != b[31]) ? {31'b0, a[31]} : {31'b0, a < b};
            SLTU: r = {31'b0, a < b};
            COPYB: r = b;
            default: r = '0;
        endcase
        return r;
    endfunction

    task automatic abortRun();
        $display("Done: errors found");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic failRun(input string reason);
        $display("Error at %0t: %s", $time, reason);
        abortRun();
    endtask

    task automatic compareValue(input string name, input logic [31:0] actual,
                                input logic [31:0] expected);
        if (actual !== expected) begin
            errorCount++;
            $display("FAILED at %0t: %s is %h, expected %h", $time, name, actual, expected);
            abortRun();
        end
    endtask

    // Drive one issue slot and run the model on it
    task automatic issueInstr(input logic valid, input logic [4:0] rs1, input logic [4:0] rs2,
                              input logic [4:0] rd, input logic regWrite, input aluOpT op,
                              input srcAT sa, input srcBT sb, input logic [31:0] pc,
                              input logic [31:0] imm);
        logic [xlen-1:0] a;
        logic [xlen-1:0] b;
        logic [xlen-1:0] result;
        @(posedge CLK);
        issueValid <= valid;
        issueRs1 <= rs1;
        issueRs2 <= rs2;
        issueRd <= rd;
        issueRegWrite <= regWrite;
        issueAluOp <= op;
        issueSrcA <= sa;
        issueSrcB <= sb;
        issuePc <= pc;
        issueImm <= imm;
        if (valid) begin
            a = (sa == PC) ? pc : modelRegs[rs1];
            b = (sb == IMM) ? imm : modelRegs[rs2];
            result = modelAlu(op, a, b);
            if (regWrite && rd != 5'd0) begin
                modelRegs[rd] = result;
            end
            expRd.push_back(rd);
            expData.push_back(result);
            // Sampled next edge, wbValid seen at the fourth negedge from here
            expCycle.push_back(cycleNum + 4);
        end
    endtask

    task automatic aluReg(input logic [4:0] rd, input logic [4:0] rs1, input logic [4:0] rs2,
                          input aluOpT op);
        issueInstr(1'b1, rs1, rs2, rd, 1'b1, op, RS1, RS2, 32'h0, 32'h0);
    endtask

    task automatic aluImm(input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm,
                          input aluOpT op);
        issueInstr(1'b1, rs1, 5'd0, rd, 1'b1, op, RS1, IMM, 32'h0, imm);
    endtask

    // Registers x0..x5 only, so hazards are frequent
    task automatic randomInstr();
        logic [31:0] v;
        logic [31:0] rs1;
        logic [31:0] rs2;
        logic [31:0] rd;
        logic [31:0] op;
        logic [31:0] sa;
        logic [31:0] sb;
        logic [31:0] wr;
        logic [31:0] pc;
        logic [31:0] imm;
        drawBits(2, v);
        drawBits(3, rs1);
        drawBits(3, rs2);
        drawBits(3, rd);
        drawBits(4, op);
        drawBits(2, sa);
        drawBits(2, sb);
        drawBits(3, wr);
        drawBits(32, pc);
        drawBits(32, imm);
        issueInstr(v != 0, 5'(rs1 % 6), 5'(rs2 % 6), 5'(rd % 6), wr != 0, aluOpT'(4'(op % 11)),
                   (sa == 0) ? PC : RS1, (sb == 0) ? IMM : RS2, pc & ~32'h3, imm);
    endtask

    // Writeback monitor, outputs stable at the falling edge
    always @(negedge CLK) begin
        cycleNum = cycleNum + 1;
        if (!rst) begin
            if (wbValid) begin
                idleCycles = 0;
                if (expRd.size() == 0) begin
                    failRun("writeback seen with no instruction in flight");
                end else begin
                    compareValue("wbRd", {27'b0, wbRd}, {27'b0, expRd.pop_front()});
                    compareValue("wbData", wbData, expData.pop_front());
                    compareValue("wbValid cycle", cycleNum, expCycle.pop_front());
                end
            end else if (expRd.size() != 0) begin
                idleCycles = idleCycles + 1;
                if (idleCycles > 10) begin
                    failRun("timeout waiting for an expected writeback");
                end
            end
        end
    end

    initial begin
        logic [31:0] v;
        logic [31:0] v2;
        int waitCycles;
        lfsrState = 32'd94339;
        cycleNum = 0;
        idleCycles = 0;
        errorCount = 0;
        for (int i = 0; i < regCount; i++) begin
            modelRegs[i] = '0;
        end
        rst = 1'b1;
        issueValid = 1'b0;
        issueRs1 = '0;
        issueRs2 = '0;
        issueRd = '0;
        issueRegWrite = 1'b0;
        issueAluOp = ADD;
        issueSrcA = RS1;
        issueSrcB = RS2;
        issuePc = '0;
        issueImm = '0;
        repeat (2) @(posedge CLK);
        rst <= 1'b0;

        // Idle after reset, monitor flags any stray wbValid
        repeat (4) issueInstr(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, ADD, RS1, RS2, 32'h0, 32'h0);
        // First instruction sees zero registers
        aluReg(5'd1, 5'd2, 5'd3, ADD);

        // Seed x1..x4, x5 negative for SRA and SLT
        for (int r = 1; r < 5; r++) begin
            drawBits(32, v);
            aluImm(5'(r), 5'd0, v, ADD);
        end
        aluImm(5'd5, 5'd0, 32'h8000_00f0, COPYB);

        // Every ALU operation, immediate and register forms
        for (int k = 0; k < 11; k++) begin
            drawBits(32, v);
            aluImm(5'd2, 5'd1, v, aluOpT'(4'(k)));
            aluReg(5'd4, 5'd5, 5'd1, aluOpT'(4'(k)));
        end

        // Dependent consumer at distance one, two and three
        for (int gap = 1; gap <= 3; gap++) begin
            drawBits(32, v);
            aluImm(5'd3, 5'd1, v, XOR);
            for (int f = 1; f < gap; f++) begin
                aluImm(5'd4, 5'd1, v, ADD);
            end
            aluReg(5'd2, 5'd3, 5'd3, ADD);
        end
        // Two producers of x3 in flight, newer one wins
        drawBits(32, v);
        drawBits(32, v2);
        aluImm(5'd3, 5'd0, v, ADD);
        aluImm(5'd3, 5'd0, v2, ADD);
        aluReg(5'd2, 5'd3, 5'd1, SUB);
        aluReg(5'd4, 5'd1, 5'd3, OR);
        // Non-writing x3 in between must not forward
        aluImm(5'd3, 5'd0, v, ADD);
        issueInstr(1'b1, 5'd1, 5'd1, 5'd3, 1'b0, ADD, RS1, RS2, 32'h0, 32'h0);
        aluReg(5'd2, 5'd3, 5'd3, ADD);

        // Write to x0, then read it at distances one to three
        drawBits(32, v);
        aluImm(5'd0, 5'd1, v, ADD);
        aluReg(5'd1, 5'd0, 5'd0, OR);
        aluReg(5'd2, 5'd0, 5'd3, ADD);
        aluReg(5'd4, 5'd3, 5'd0, SUB);

        // AUIPC and LUI style sources
        drawBits(32, v);
        issueInstr(1'b1, 5'd0, 5'd0, 5'd3, 1'b1, ADD, PC, IMM, 32'h0000_1000, v);
        issueInstr(1'b1, 5'd0, 5'd0, 5'd4, 1'b1, COPYB, RS1, IMM, 32'h0, v & 32'hffff_f000);
        aluReg(5'd2, 5'd3, 5'd4, ADD);

        // Random mix with bubbles and non-writing instructions
        repeat (300) randomInstr();
        issueInstr(1'b0, 5'd0, 5'd0, 5'd0, 1'b0, ADD, RS1, RS2, 32'h0, 32'h0);

        // Drain the pipeline
        for (waitCycles = 0; waitCycles < 10 && expRd.size() != 0; waitCycles++) begin
            @(posedge CLK);
        end
        if (expRd.size() != 0) begin
            failRun("timeout draining the pipeline");
        end
        repeat (2) @(posedge CLK);

        if (errorCount == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire
